// File: hw/spmm_pkg.sv
// Shared sizes, value types and memory word formats of the sparse-by-dense multiplier
package spmm_pkg;

  // ========================================
  // Fixed sizes
  // ========================================
  localparam int MAX_FEATURE_IN  = 64;
  localparam int MAX_NODES       = 64;
  localparam int NODE_FIFO_DEPTH = 4;

  localparam int DATA_W     = 8;
  localparam int WH_DATA_W  = 20;
  localparam int COL_IDX_W  = $clog2(MAX_FEATURE_IN);
  // One extra bit so a full row of MAX_FEATURE_IN entries fits
  localparam int ROW_LEN_W  = $clog2(MAX_FEATURE_IN) + 1;
  localparam int NUM_NODE_W = $clog2(MAX_NODES);

  // ========================================
  // Value types
  // ========================================
  typedef logic signed [DATA_W-1:0]    data_t;
  typedef logic        [COL_IDX_W-1:0] col_idx_t;
  typedef logic        [ROW_LEN_W-1:0] row_len_t;
  typedef logic        [NUM_NODE_W-1:0] num_node_t;
  // Accumulated Wh element, wraps modulo 2^20
  typedef logic signed [WH_DATA_W-1:0] wh_data_t;

  // H data memory word
  typedef struct packed {
    col_idx_t col_idx;
    data_t    val;
  } h_entry_t;

  // Descriptor memory word, one per H row
  typedef struct packed {
    row_len_t  row_len;
    num_node_t num_node;
    logic      src_flag;
  } node_info_t;

  // Row metadata appended to each Wh word
  typedef struct packed {
    num_node_t num_node;
    logic      src_flag;
  } wh_meta_t;

endpackage

// File: hw/h_data_fetch.sv
// Sparse entry fetcher, reads H data words and presents one entry at a time
`timescale 1ns/1ps

module h_data_fetch
  import spmm_pkg::*;
#(
  parameter int  H_DEPTH = 32,
  localparam int ADDR_W  = $clog2(H_DEPTH)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spmm_vld_i,
  input  h_entry_t          h_data_dout_i,
  input  logic              entry_take_i,
  output logic [ADDR_W-1:0] h_data_addr_o,
  output h_entry_t          entry_o,
  output logic              entry_vld_o
);

  logic       started;
  logic       last_addr;
  logic       issue;
  // Bit 0 set the cycle a new address shows, bit 1 when its word returns
  logic [1:0] rd_pend;

  assign last_addr = (h_data_addr_o == ADDR_W'(H_DEPTH - 1));
  assign issue     = (spmm_vld_i && !started) || (entry_take_i && !last_addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_data_addr_o <= '0;
      started       <= 1'b0;
      rd_pend       <= '0;
      entry_vld_o   <= 1'b0;
    end else begin
      if (spmm_vld_i) begin
        started <= 1'b1;
      end
      if (entry_take_i && !last_addr) begin
        h_data_addr_o <= h_data_addr_o + ADDR_W'(1);
      end
      rd_pend <= {rd_pend[0], issue};
      if (entry_take_i) begin
        entry_vld_o <= 1'b0;
      end else if (rd_pend[1]) begin
        entry_vld_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pend[1]) begin
      entry_o <= h_data_dout_i;
    end
  end

endmodule

// File: hw/node_info_fetch.sv
// Row descriptor prefetcher, keeps a small FIFO of node descriptors ahead of the lanes
`timescale 1ns/1ps

module node_info_fetch
  import spmm_pkg::*;
#(
  parameter int  TOTAL_NODES = 8,
  localparam int ADDR_W      = $clog2(TOTAL_NODES)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spmm_vld_i,
  input  node_info_t        node_info_dout_i,
  input  logic              desc_pop_i,
  output logic [ADDR_W-1:0] node_info_addr_o,
  output node_info_t        desc_o,
  output logic              desc_vld_o
);

  localparam int PTR_W = $clog2(NODE_FIFO_DEPTH);
  localparam int CNT_W = $clog2(NODE_FIFO_DEPTH + 1);

  node_info_t       fifo_mem [NODE_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] used;
  logic [CNT_W-1:0] in_flight;
  logic             all_issued;
  logic             room;
  logic             issue;
  logic             push;

  // Reads still in flight already own a FIFO slot
  assign room   = (used + in_flight < NODE_FIFO_DEPTH) || desc_pop_i;
  assign issue  = spmm_vld_i && !all_issued && room;
  // Memory answers one cycle after the address
  assign push   = (in_flight != '0);

  assign desc_vld_o = (used != '0);
  assign desc_o     = fifo_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_info_addr_o <= '0;
      all_issued       <= 1'b0;
      in_flight        <= '0;
      used             <= '0;
      wr_ptr           <= '0;
      rd_ptr           <= '0;
    end else begin
      if (issue) begin
        if (node_info_addr_o == ADDR_W'(TOTAL_NODES - 1)) begin
          all_issued <= 1'b1;
        end else begin
          node_info_addr_o <= node_info_addr_o + ADDR_W'(1);
        end
      end
      in_flight <= in_flight + CNT_W'(issue) - CNT_W'(push);
      used      <= used + CNT_W'(push) - CNT_W'(desc_pop_i);
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (desc_pop_i) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= node_info_dout_i;
    end
  end

endmodule

// File: hw/sp_pe.sv
// Single output-feature lane, multiplies entries by its weight column and sums a row
`timescale 1ns/1ps

module sp_pe
  import spmm_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     take_i,
  input  logic     first_i,
  input  logic     last_i,
  input  h_entry_t entry_i,
  input  data_t    wgt_dout_i,
  output col_idx_t wgt_addr_o,
  output wh_data_t res_o,
  output logic     res_vld_o
);

  logic     mac_vld;
  logic     first_q;
  logic     last_q;
  data_t    val_q;
  wh_data_t prod;
  wh_data_t acc;

  // Weight row selected by the entry column, word returns next cycle
  assign wgt_addr_o = entry_i.col_idx;
  assign prod       = wh_data_t'(val_q) * wh_data_t'(wgt_dout_i);
  assign res_o      = acc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mac_vld   <= 1'b0;
      res_vld_o <= 1'b0;
    end else begin
      mac_vld   <= take_i;
      res_vld_o <= mac_vld && last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (take_i) begin
      val_q   <= entry_i.val;
      first_q <= first_i;
      last_q  <= last_i;
    end
    // First entry of a row restarts the sum
    if (mac_vld) begin
      acc <= first_q ? prod : acc + prod;
    end
  end

endmodule

// File: hw/sppe_array.sv
// Row sequencer, pairs entries with their descriptor and drives every lane
`timescale 1ns/1ps

module sppe_array
  import spmm_pkg::*;
#(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  h_entry_t                         entry_i,
  input  logic                             entry_vld_i,
  input  node_info_t                       desc_i,
  input  logic                             desc_vld_i,
  input  data_t    [NUM_FEATURE_OUT-1:0]   wgt_dout_i,
  output logic                             entry_take_o,
  output logic                             desc_pop_o,
  output col_idx_t [NUM_FEATURE_OUT-1:0]   wgt_addr_o,
  output logic                             row_done_o,
  output wh_data_t [NUM_FEATURE_OUT-1:0]   row_res_o,
  output wh_meta_t                         row_meta_o
);

  row_len_t                   cnt;
  logic                       first_ent;
  logic                       last_ent;
  logic [NUM_FEATURE_OUT-1:0] lane_vld;
  wh_meta_t                   meta_d1;
  wh_meta_t                   meta_d2;

  assign entry_take_o = entry_vld_i && desc_vld_i;
  assign first_ent    = (cnt == '0);
  assign last_ent     = (cnt == desc_i.row_len - row_len_t'(1));
  assign desc_pop_o   = entry_take_o && last_ent;
  assign row_done_o   = &lane_vld;
  assign row_meta_o   = meta_d2;

  // Entry position within the current row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (entry_take_o) begin
      cnt <= last_ent ? '0 : cnt + row_len_t'(1);
    end
  end

  // Two stages, matching the lane take-to-result delay
  always_ff @(posedge clk) begin
    if (desc_pop_o) begin
      meta_d1 <= '{num_node: desc_i.num_node, src_flag: desc_i.src_flag};
    end
    meta_d2 <= meta_d1;
  end

  // ========================================
  // Lanes, one per output feature
  // ========================================
  for (genvar i = 0; i < NUM_FEATURE_OUT; i++) begin : g_lane
    sp_pe u_sp_pe (
      .clk        (clk),
      .rst_n      (rst_n),
      .take_i     (entry_take_o),
      .first_i    (first_ent),
      .last_i     (last_ent),
      .entry_i    (entry_i),
      .wgt_dout_i (wgt_dout_i[i]),
      .wgt_addr_o (wgt_addr_o[i]),
      .res_o      (row_res_o[i]),
      .res_vld_o  (lane_vld[i])
    );
  end

endmodule

// File: hw/wh_writer.sv
// Result writer, stores finished rows to Wh memory and subgraph sizes to num-node memory
`timescale 1ns/1ps

module wh_writer
  import spmm_pkg::*;
#(
  parameter int  NUM_FEATURE_OUT = 4,
  parameter int  TOTAL_NODES     = 8,
  parameter int  NUM_SUBGRAPHS   = 8,
  localparam int WH_ADDR_W       = $clog2(TOTAL_NODES),
  localparam int NN_ADDR_W       = $clog2(NUM_SUBGRAPHS),
  localparam int WH_WIDTH        = NUM_FEATURE_OUT * $bits(wh_data_t) + $bits(wh_meta_t)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           row_done_i,
  input  wh_data_t [NUM_FEATURE_OUT-1:0] row_res_i,
  input  wh_meta_t                       row_meta_i,
  output logic                           wh_bram_ena_o,
  output logic [WH_ADDR_W-1:0]           wh_bram_addra_o,
  output logic [WH_WIDTH-1:0]            wh_bram_din_o,
  output logic                           num_node_bram_ena_o,
  output logic [NN_ADDR_W-1:0]           num_node_bram_addra_o,
  output num_node_t                      num_node_bram_din_o,
  output logic                           spmm_done_o
);

  localparam int LANE_W = $bits(wh_data_t);

  logic [WH_WIDTH-1:0] wh_word;
  logic                wr_en;

  assign wr_en = row_done_i && !spmm_done_o;

  // Lane 0 lands in the top bits, metadata in the bottom
  always_comb begin
    wh_word = '0;
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      wh_word[WH_WIDTH-1-i*LANE_W -: LANE_W] = row_res_i[i];
    end
    wh_word[$bits(wh_meta_t)-1:0] = row_meta_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_bram_ena_o         <= 1'b0;
      wh_bram_addra_o       <= '0;
      num_node_bram_ena_o   <= 1'b0;
      num_node_bram_addra_o <= '0;
      spmm_done_o           <= 1'b0;
    end else begin
      wh_bram_ena_o       <= wr_en;
      num_node_bram_ena_o <= wr_en && row_meta_i.src_flag;
      // Address moves on after each write, done follows the last one
      if (wh_bram_ena_o) begin
        if (wh_bram_addra_o == WH_ADDR_W'(TOTAL_NODES - 1)) begin
          spmm_done_o <= 1'b1;
        end else begin
          wh_bram_addra_o <= wh_bram_addra_o + WH_ADDR_W'(1);
        end
      end
      if (num_node_bram_ena_o &&
          num_node_bram_addra_o != NN_ADDR_W'(NUM_SUBGRAPHS - 1)) begin
        num_node_bram_addra_o <= num_node_bram_addra_o + NN_ADDR_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      wh_bram_din_o       <= wh_word;
      num_node_bram_din_o <= row_meta_i.num_node;
    end
  end

endmodule

// File: hw/spmm_top.sv
// Feature-times-weight stage Wh = H x W, sparse H rows against a dense weight matrix
`timescale 1ns/1ps

module spmm_top
  import spmm_pkg::*;
#(
  parameter int  NUM_FEATURE_OUT = 4,
  parameter int  TOTAL_NODES     = 8,
  parameter int  H_DEPTH         = 32,
  parameter int  NUM_SUBGRAPHS   = 8,
  localparam int H_ADDR_W        = $clog2(H_DEPTH),
  localparam int NI_ADDR_W       = $clog2(TOTAL_NODES),
  localparam int WH_ADDR_W       = $clog2(TOTAL_NODES),
  localparam int NN_ADDR_W       = $clog2(NUM_SUBGRAPHS),
  localparam int WH_WIDTH        = NUM_FEATURE_OUT * $bits(wh_data_t) + $bits(wh_meta_t)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           spmm_vld_i,
  input  h_entry_t                       h_data_dout_i,
  input  node_info_t                     node_info_dout_i,
  input  data_t    [NUM_FEATURE_OUT-1:0] wgt_dout_i,
  output logic [H_ADDR_W-1:0]            h_data_addr_o,
  output logic [NI_ADDR_W-1:0]           node_info_addr_o,
  output col_idx_t [NUM_FEATURE_OUT-1:0] wgt_addr_o,
  output logic                           wh_bram_ena_o,
  output logic [WH_ADDR_W-1:0]           wh_bram_addra_o,
  output logic [WH_WIDTH-1:0]            wh_bram_din_o,
  output logic                           num_node_bram_ena_o,
  output logic [NN_ADDR_W-1:0]           num_node_bram_addra_o,
  output num_node_t                      num_node_bram_din_o,
  output logic                           spmm_done_o
);

  h_entry_t                       entry;
  logic                           entry_vld;
  logic                           entry_take;
  node_info_t                     desc;
  logic                           desc_vld;
  logic                           desc_pop;
  logic                           row_done;
  wh_data_t [NUM_FEATURE_OUT-1:0] row_res;
  wh_meta_t                       row_meta;

  // ========================================
  // Fetchers, running side by side
  // ========================================
  h_data_fetch #(
    .H_DEPTH (H_DEPTH)
  ) u_h_data_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .spmm_vld_i    (spmm_vld_i),
    .h_data_dout_i (h_data_dout_i),
    .entry_take_i  (entry_take),
    .h_data_addr_o (h_data_addr_o),
    .entry_o       (entry),
    .entry_vld_o   (entry_vld)
  );

  node_info_fetch #(
    .TOTAL_NODES (TOTAL_NODES)
  ) u_node_info_fetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .spmm_vld_i       (spmm_vld_i),
    .node_info_dout_i (node_info_dout_i),
    .desc_pop_i       (desc_pop),
    .node_info_addr_o (node_info_addr_o),
    .desc_o           (desc),
    .desc_vld_o       (desc_vld)
  );

  // ========================================
  // Lanes and result writer
  // ========================================
  sppe_array #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_sppe_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .entry_i      (entry),
    .entry_vld_i  (entry_vld),
    .desc_i       (desc),
    .desc_vld_i   (desc_vld),
    .wgt_dout_i   (wgt_dout_i),
    .entry_take_o (entry_take),
    .desc_pop_o   (desc_pop),
    .wgt_addr_o   (wgt_addr_o),
    .row_done_o   (row_done),
    .row_res_o    (row_res),
    .row_meta_o   (row_meta)
  );

  wh_writer #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES),
    .NUM_SUBGRAPHS   (NUM_SUBGRAPHS)
  ) u_wh_writer (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .row_done_i            (row_done),
    .row_res_i             (row_res),
    .row_meta_i            (row_meta),
    .wh_bram_ena_o         (wh_bram_ena_o),
    .wh_bram_addra_o       (wh_bram_addra_o),
    .wh_bram_din_o         (wh_bram_din_o),
    .num_node_bram_ena_o   (num_node_bram_ena_o),
    .num_node_bram_addra_o (num_node_bram_addra_o),
    .num_node_bram_din_o   (num_node_bram_din_o),
    .spmm_done_o           (spmm_done_o)
  );

endmodule

// File: verif/spmm_assert.sv
// Concurrent checks on the Wh and num-node write ports and the done level
`timescale 1ns/1ps

module spmm_assert #(
  parameter int TOTAL_NODES = 8,
  parameter int WH_ADDR_W   = 3
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 wh_ena_i,
  input logic [WH_ADDR_W-1:0] wh_addr_i,
  input logic                 nn_ena_i,
  input logic                 done_i
);

  // Wh writes seen since reset, one spare bit to count past the last row
  logic [WH_ADDR_W:0] wr_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
    end else if (wh_ena_i) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  wh_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wh_ena_i |-> (wr_cnt < TOTAL_NODES) && (wh_addr_i == wr_cnt))
    else $error("Wh write address out of order or beyond the node range");

  // Once done, the writer stays quiet
  no_write_when_done: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> !(wh_ena_i || nn_ena_i))
    else $error("Write enable high while done is set");

  done_holds: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> done_i)
    else $error("Done fell before reset");

endmodule

bind spmm_top spmm_assert #(
  .TOTAL_NODES (TOTAL_NODES),
  .WH_ADDR_W   (WH_ADDR_W)
) u_spmm_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .wh_ena_i  (wh_bram_ena_o),
  .wh_addr_i (wh_bram_addra_o),
  .nn_ena_i  (num_node_bram_ena_o),
  .done_i    (spmm_done_o)
);

// File: verif/spmm_tb.sv
// Directed testbench for the sparse-by-dense multiplier with memory models and a golden model
`timescale 1ns/1ps

module spmm_tb
  import spmm_pkg::*;
();

  localparam int NUM_FEATURE_OUT = 4;
  localparam int TOTAL_NODES     = 8;
  localparam int H_DEPTH         = 32;
  localparam int LANE_W          = $bits(wh_data_t);
  localparam int META_W          = $bits(wh_meta_t);
  localparam int WH_WIDTH        = NUM_FEATURE_OUT * LANE_W + META_W;
  localparam int CLK_PERIOD      = 10;
  localparam int NUM_TESTS       = 5;
  localparam int TEST_CYCLES     = 400;

  logic                           clk = 1'b0;
  logic                           rst_n = 1'b0;
  logic                           spmm_vld = 1'b0;
  h_entry_t                       h_data_dout = '0;
  node_info_t                     node_info_dout = '0;
  data_t    [NUM_FEATURE_OUT-1:0] wgt_dout = '0;
  logic [4:0]                     h_data_addr;
  logic [2:0]                     node_info_addr;
  col_idx_t [NUM_FEATURE_OUT-1:0] wgt_addr;
  logic                           wh_ena;
  logic [2:0]                     wh_addr;
  logic [WH_WIDTH-1:0]            wh_din;
  logic                           nn_ena;
  logic [2:0]                     nn_addr;
  num_node_t                      nn_din;
  logic                           done;

  h_entry_t            h_mem  [H_DEPTH];
  node_info_t          ni_mem [TOTAL_NODES];
  data_t               w_mem  [NUM_FEATURE_OUT][MAX_FEATURE_IN];
  logic [WH_WIDTH-1:0] exp_wh [TOTAL_NODES];
  num_node_t           exp_nn [$];
  int                  err_cnt = 0;
  int                  check_cnt = 0;
  int                  seed = 32'h923615d5;

  spmm_top DUT (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .spmm_vld_i            (spmm_vld),
    .h_data_dout_i         (h_data_dout),
    .node_info_dout_i      (node_info_dout),
    .wgt_dout_i            (wgt_dout),
    .h_data_addr_o         (h_data_addr),
    .node_info_addr_o      (node_info_addr),
    .wgt_addr_o            (wgt_addr),
    .wh_bram_ena_o         (wh_ena),
    .wh_bram_addra_o       (wh_addr),
    .wh_bram_din_o         (wh_din),
    .num_node_bram_ena_o   (nn_ena),
    .num_node_bram_addra_o (nn_addr),
    .num_node_bram_din_o   (nn_din),
    .spmm_done_o           (done)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Read memories, word one cycle after the address
  always @(posedge clk) begin
    h_data_dout    <= h_mem[h_data_addr];
    node_info_dout <= ni_mem[node_info_addr];
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      wgt_dout[i] <= w_mem[i][wgt_addr[i]];
    end
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic report_error(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    spmm_vld = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Golden model, row sums of value times weight, lane 0 on top then metadata
  task automatic compute_expected();
    int                  e;
    int                  p;
    data_t               v;
    data_t               w;
    wh_data_t            acc [NUM_FEATURE_OUT];
    logic [WH_WIDTH-1:0] word;
    e = 0;
    exp_nn.delete();
    for (int r = 0; r < TOTAL_NODES; r++) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        acc[l] = '0;
      end
      for (int k = 0; k < int'(ni_mem[r].row_len); k++) begin
        for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
          v      = h_mem[e].val;
          w      = w_mem[l][h_mem[e].col_idx];
          p      = int'(v) * int'(w);
          acc[l] = acc[l] + wh_data_t'(p);
        end
        e++;
      end
      word = '0;
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        word = {word[WH_WIDTH-LANE_W-1:0], acc[l]};
      end
      word      = {word[WH_WIDTH-META_W-1:0], ni_mem[r].num_node, ni_mem[r].src_flag};
      exp_wh[r] = word;
      if (ni_mem[r].src_flag) begin
        exp_nn.push_back(ni_mem[r].num_node);
      end
    end
  endtask

  // Start the run, check every write, then watch 50 idle cycles after done
  task automatic run_and_check(string name);
    int wh_cnt;
    int nn_cnt;
    int cyc;
    wh_cnt = 0;
    nn_cnt = 0;
    cyc    = 0;
    compute_expected();
    @(posedge clk);
    #1;
    spmm_vld = 1'b1;
    while (!done && cyc < 300) begin
      @(negedge clk);
      cyc++;
      if (wh_ena) begin
        check_cnt++;
        if (wh_cnt >= TOTAL_NODES) begin
          report_error($sformatf("%s: Wh write beyond the last row", name));
        end else if (wh_addr != wh_cnt || wh_din !== exp_wh[wh_cnt]) begin
          report_error($sformatf("%s: row %0d addr %0d data %h, expected %h", name,
                                 wh_cnt, wh_addr, wh_din, exp_wh[wh_cnt]));
        end
        wh_cnt++;
      end
      if (nn_ena) begin
        check_cnt++;
        if (nn_cnt >= exp_nn.size()) begin
          report_error($sformatf("%s: num-node write for a row without the flag", name));
        end else if (nn_addr != nn_cnt || nn_din !== exp_nn[nn_cnt]) begin
          report_error($sformatf("%s: num-node %0d addr %0d data %0d, expected %0d", name,
                                 nn_cnt, nn_addr, nn_din, exp_nn[nn_cnt]));
        end
        nn_cnt++;
      end
    end
    if (!done) begin
      report_error($sformatf("%s: done did not rise within 300 cycles", name));
    end
    if (wh_cnt != TOTAL_NODES || nn_cnt != exp_nn.size()) begin
      report_error($sformatf("%s: %0d Wh and %0d num-node writes, expected %0d and %0d",
                             name, wh_cnt, nn_cnt, TOTAL_NODES, exp_nn.size()));
    end
    repeat (50) begin
      @(negedge clk);
      if (wh_ena || nn_ena || !done) begin
        report_error($sformatf("%s: write or done drop after the run finished", name));
      end
    end
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic check_idle_after_reset();
    apply_reset();
    repeat (20) begin
      @(negedge clk);
      check_cnt++;
      if (wh_ena || nn_ena || done) begin
        report_error("idle: write or done while spmm_vld_i is low");
      end
    end
  endtask

  task automatic test_single_entry_rows();
    apply_reset();
    for (int c = 0; c < MAX_FEATURE_IN; c++) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        w_mem[l][c] = data_t'(c * 3 - 40 + l * 17);
      end
    end
    for (int r = 0; r < TOTAL_NODES; r++) begin
      ni_mem[r] = '{row_len: row_len_t'(1), num_node: num_node_t'(r + 2),
                    src_flag: (r % 3 == 0)};
      h_mem[r]  = '{col_idx: col_idx_t'(r * 7), val: data_t'(r - 3)};
    end
    run_and_check("single entry");
  endtask

  // Row lengths 1 to 6, kept within the H memory depth
  task automatic test_random_rows(string name, bit all_src);
    int used;
    int max_len;
    int len;
    apply_reset();
    for (int c = 0; c < MAX_FEATURE_IN; c++) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        w_mem[l][c] = data_t'($random(seed));
      end
    end
    used = 0;
    for (int r = 0; r < TOTAL_NODES; r++) begin
      max_len = H_DEPTH - used - (TOTAL_NODES - 1 - r);
      if (max_len > 6) begin
        max_len = 6;
      end
      len       = 1 + rand_below(max_len);
      ni_mem[r] = '{row_len: row_len_t'(len), num_node: num_node_t'(rand_below(MAX_NODES)),
                    src_flag: all_src || (rand_below(2) == 1)};
      for (int k = 0; k < len; k++) begin
        h_mem[used] = '{col_idx: col_idx_t'(rand_below(MAX_FEATURE_IN)),
                        val: data_t'($random(seed))};
        used++;
      end
    end
    run_and_check(name);
  endtask

  initial begin
    check_idle_after_reset();
    test_single_entry_rows();
    test_random_rows("random rows A", 1'b0);
    test_random_rows("random rows B", 1'b0);
    test_random_rows("all source rows", 1'b1);
    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the test count and the cycles each test may need
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: vlog.f
hw/spmm_pkg.sv
hw/h_data_fetch.sv
hw/node_info_fetch.sv
hw/sp_pe.sv
hw/sppe_array.sv
hw/wh_writer.sv
hw/spmm_top.sv
verif/spmm_assert.sv
verif/spmm_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the multiplier testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module spmm_tb -f vlog.f -o spmm_sim &&
  ./obj_dir/spmm_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }
